//--- daqTop.sv
`timescale 1ns/1ps

module daqTop #(
    parameter int SyncStages    = 2,
    parameter int HoldTimeWidth = 12,
    parameter int CountWidth    = 16
) (
    input  logic                  Clk,        // 40 MHz system clock
    input  logic                  arstN,
    // USB control words
    input  logic                  cmdValid,
    input  microrocPkg::cmdWord_u cmdWord,
    // MICROROC trigger pins
    input  microrocPkg::trigPins_t trigPins,
    output logic                  trigOut,    // Coincidence pulse
    // Hold path
    output logic                  hold,
    output logic [CountWidth-1:0] eventCount
);
    import microrocPkg::*;

    daqParams_t params; // Decoded hold settings

    ////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////
    usbCommandDecoder uCmdDecoder (
        .Clk      (Clk),
        .arstN    (arstN),
        .cmdValid (cmdValid),
        .cmdWord  (cmdWord),
        .params   (params)
    );

    ////////////////////////////////////////////////////////////
    // Trigger coincidence and hold
    ////////////////////////////////////////////////////////////
    trigCoincid #(
        .SyncStages (SyncStages)
    ) uTrigCoincid (
        .Clk       (Clk),
        .arstN     (arstN),
        .trigPins  (trigPins),
        .coincMode (params.coincMode),
        .trigPulse (trigOut)          // Also feeds the hold generator
    );

    holdGen #(
        .HoldTimeWidth (HoldTimeWidth),
        .CountWidth    (CountWidth)
    ) uHoldGen (
        .Clk        (Clk),
        .arstN      (arstN),
        .trigPulse  (trigOut),
        .params     (params),
        .hold       (hold),
        .eventCount (eventCount)
    );

endmodule

//--- holdGen.sv
`timescale 1ns/1ps

module holdGen #(
    parameter int HoldTimeWidth = 12, // Down-counter width
    parameter int CountWidth    = 16  // Event counter width
) (
    input  logic                    Clk,
    input  logic                    arstN,
    input  logic                    trigPulse,
    input  microrocPkg::daqParams_t params,
    output logic                    hold,
    output logic [CountWidth-1:0]   eventCount // Holds issued
);
    import microrocPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stDelay,
        stHold
    } state_t;

    state_t                   state;
    logic [HoldTimeWidth-1:0] cnt;       // Shared delay/hold counter
    logic [HoldTimeWidth-1:0] holdLoad;  // Hold cycles minus one
    logic [HoldTimeWidth-1:0] delayLoad; // Delay cycles minus one
    logic                     accept;

    // Only idle listens, both enables required
    assign accept = (state == stIdle) & trigPulse & params.trigEn & params.holdEn;

    always_comb begin
        if (params.holdTime == 12'd0) begin
            holdLoad = '0; // Zero width runs as one cycle
        end else begin
            holdLoad = HoldTimeWidth'(params.holdTime - 12'd1);
        end
        delayLoad = HoldTimeWidth'(params.holdDelay - 8'd1); // Unused when delay is 0
    end

    ////////////////////////////////////////////////////////////
    // Delay then hold FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state      <= stIdle;
            cnt        <= '0;
            hold       <= 1'b0;
            eventCount <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (accept && (params.holdDelay == 8'd0)) begin
                        state      <= stHold;  // No delay, hold next cycle
                        cnt        <= holdLoad;
                        hold       <= 1'b1;
                        eventCount <= eventCount + 1'b1;
                    end else if (accept) begin
                        state <= stDelay;
                        cnt   <= delayLoad;
                    end
                end
                stDelay: begin
                    if (cnt == '0) begin
                        state      <= stHold;
                        cnt        <= holdLoad;
                        hold       <= 1'b1;
                        eventCount <= eventCount + 1'b1; // Count on HOLD rise
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                stHold: begin
                    if (cnt == '0) begin
                        state <= stIdle; // Triggers during hold are lost
                        hold  <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= stIdle;
                    hold  <= 1'b0;
                end
            endcase
        end
    end

    assert property (@(posedge Clk) disable iff (!arstN)
        (state == stIdle) |-> !hold)
        else $error("HOLD high while idle");

    assert property (@(posedge Clk) disable iff (!arstN)
        $changed(eventCount) |-> $rose(hold))
        else $error("eventCount moved without a HOLD rise");

endmodule

//--- microrocPkg.sv
package microrocPkg;

    ////////////////////////////////////////////////////////////
    // Trigger coincidence
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        coincAny      = 2'd0, // Any ASIC trigger
        coincAll      = 2'd1, // All three ASICs
        coincMajority = 2'd2, // Two out of three
        coincExternal = 2'd3  // External pin only
    } coincMode_t;

    ////////////////////////////////////////////////////////////
    // USB control words
    ////////////////////////////////////////////////////////////
    localparam logic [3:0] opCoincMode = 4'hA; // Value[1:0] = mode
    localparam logic [3:0] opHoldDelay = 4'hB; // Value[7:0] = delay
    localparam logic [3:0] opHoldTime  = 4'hC; // Full 12-bit value
    localparam logic [3:0] opFlag      = 4'hD; // Single-bit switches

    localparam logic [3:0] flagHoldEn = 4'd0;
    localparam logic [3:0] flagTrigEn = 4'd1;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] value;
    } valueCmd_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] flagIdx;
        logic [6:0] rsvd;    // Don't care
        logic       flagVal;
    } flagCmd_t;

    // Same 16 bits, opcode always on top
    typedef union packed {
        valueCmd_t valueCmd;
        flagCmd_t  flagCmd;
    } cmdWord_u;

    ////////////////////////////////////////////////////////////
    // Stored parameters and pins
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        coincMode_t  coincMode;
        logic [7:0]  holdDelay; // Clk cycles before HOLD
        logic [11:0] holdTime;  // HOLD width in Clk cycles
        logic        holdEn;
        logic        trigEn;
    } daqParams_t;

    typedef struct packed {
        logic trig0B;   // ASIC triggers, active low
        logic trig1B;
        logic trig2B;
        logic extTrigB; // External trigger pin
    } trigPins_t;

    localparam coincMode_t  resetCoincMode = coincAny;
    localparam logic [7:0]  resetHoldDelay = 8'd4;
    localparam logic [11:0] resetHoldTime  = 12'd16;

    localparam daqParams_t resetParams = '{
        coincMode: resetCoincMode,
        holdDelay: resetHoldDelay,
        holdTime:  resetHoldTime,
        holdEn:    1'b0,  // Hold path off until enabled
        trigEn:    1'b0
    };

endpackage

//--- run.sh
#!/bin/sh
# Build and run tbDaqTop with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbDaqTop \
    -f tb.f -o simTb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0

//--- tb.f
microrocPkg.sv
usbCommandDecoder.sv
trigCoincid.sv
holdGen.sv
daqTop.sv
tbDaqTop.sv

//--- tbDaqTop.sv
`timescale 1ns/1ps

module tbDaqTop;
    import microrocPkg::*;

    localparam int NumRows     = 24;
    localparam int ResetCycles = 16;
    localparam logic yes = 1'b1;
    localparam logic no  = 1'b0;
    localparam logic [3:0] p0 = 4'b1000; // Pulled-low masks in trigPins_t bit order
    localparam logic [3:0] p1 = 4'b0100;
    localparam logic [3:0] p2 = 4'b0010;
    localparam logic [3:0] pX = 4'b0001; // External pin

    typedef struct packed {
        logic        doProgram; // Send the five setup words
        logic [15:0] extraWord; // Sent after setup when nonzero
        coincMode_t  mode;
        logic [7:0]  delay;
        logic [11:0] holdTime;
        logic        holdEn;
        logic        trigEn;
        logic [3:0]  pins;      // Pins pulled low
        logic        expTrig;
        logic        expHold;
        logic        retrig;    // Second pulse while busy
    } testRow_t;

    logic        Clk = 1'b0;
    logic        arstN;
    logic        cmdValid;
    cmdWord_u    cmdWord;
    trigPins_t   trigPins;
    logic        trigOut;
    logic        hold;
    logic [15:0] eventCount;
    testRow_t    rows [NumRows];
    int          cycles = 0;
    int          cycleLimit = 0; // Zero until worked out
    int          refHolds = 0;   // Expected eventCount
    int          trigCount = 0;
    int          trigCycle = 0;
    int          riseCount = 0;
    int          riseCycle = 0;
    int          fallCount = 0;
    int          fallCycle = 0;
    logic        holdLast = 1'b0;

    daqTop #(
        .SyncStages    (2),
        .HoldTimeWidth (12),
        .CountWidth    (16)
    ) u_dut (
        .Clk        (Clk),
        .arstN      (arstN),
        .cmdValid   (cmdValid),
        .cmdWord    (cmdWord),
        .trigPins   (trigPins),
        .trigOut    (trigOut),
        .hold       (hold),
        .eventCount (eventCount)
    );

    always #2 Clk = ~Clk; // 4 ns period

    ////////////////////////////////////////////////////////////
    // Cycle count, timeout and edge monitor
    ////////////////////////////////////////////////////////////
    always @(posedge Clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            stopRun($sformatf("Timeout, run exceeded %0d cycles", cycleLimit));
        end
    end

    // Sampled mid-cycle on settled outputs
    always @(negedge Clk) begin
        if (arstN) begin
            if (trigOut) begin
                trigCount++;
                trigCycle = cycles;
            end
            if (hold && !holdLast) begin
                riseCount++;
                riseCycle = cycles;
            end
            if (!hold && holdLast) begin
                fallCount++;
                fallCycle = cycles;
            end
            holdLast = hold;
        end
    end

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stopRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic tick();
        @(posedge Clk);
        #1; // Drive point after the edge
    endtask

    task automatic sendCmd(input logic [15:0] word);
        cmdValid = 1'b1;
        cmdWord  = word;
        tick();
        cmdValid = 1'b0;
        cmdWord  = '0;
    endtask

    task automatic pulsePins(input logic [3:0] pins, input int len);
        trigPins = ~pins;
        repeat (len) tick();
        trigPins = '1; // All released
    endtask

    function automatic int worstSpan();
        int maxDelay;
        int maxTime;
        maxDelay = 0;
        maxTime  = 0;
        foreach (rows[i]) begin
            if (int'(rows[i].delay) > maxDelay) maxDelay = rows[i].delay;
            if (int'(rows[i].holdTime) > maxTime) maxTime = rows[i].holdTime;
        end
        return maxDelay + maxTime;
    endfunction

    ////////////////////////////////////////////////////////////
    // One table row
    ////////////////////////////////////////////////////////////
    task automatic runRow(input testRow_t row, input int idx);
        int    trigBefore;
        int    riseBefore;
        int    fallBefore;
        int    firstTrig;
        int    waited;
        int    expWidth;
        string tag;
        expWidth = (row.holdTime == 12'd0) ? 1 : int'(row.holdTime); // Zero acts as one
        tag      = $sformatf("row %0d", idx);
        if (row.doProgram) begin
            sendCmd({opCoincMode, 10'd0, row.mode});
            sendCmd({opHoldDelay, 4'd0, row.delay});
            sendCmd({opHoldTime, row.holdTime});
            sendCmd({opFlag, flagHoldEn, 7'd0, row.holdEn});
            sendCmd({opFlag, flagTrigEn, 7'd0, row.trigEn});
        end
        if (row.extraWord != 16'h0000) sendCmd(row.extraWord); // Should be ignored
        trigBefore = trigCount;
        riseBefore = riseCount;
        fallBefore = fallCount;
        pulsePins(row.pins, 4);
        waited = 0;
        while (trigCount == trigBefore && waited < 8) begin
            tick();
            waited++;
        end
        if (row.expTrig && trigCount == trigBefore) stopRun({tag, " got no trigOut pulse"});
        if (!row.expTrig && trigCount != trigBefore) stopRun({tag, " got an unexpected trigOut"});
        firstTrig = trigCycle;
        if (row.retrig) begin
            repeat (2) tick(); // Let the combined trigger fall first
            pulsePins(row.pins, 3);
            waited = 0;
            while (trigCount < trigBefore + 2 && waited < 8) begin
                tick();
                waited++;
            end
            if (trigCount != trigBefore + 2) stopRun({tag, " second trigOut pulse missing"});
        end
        if (row.expHold) begin
            waited = 0;
            while (riseCount == riseBefore && waited < row.delay + 8) begin
                tick();
                waited++;
            end
            if (riseCount == riseBefore) stopRun({tag, " HOLD never rose after trigOut"});
            checkValue({tag, " trigOut to HOLD"}, riseCycle - firstTrig, row.delay + 1);
            waited = 0;
            while (fallCount == fallBefore && waited < expWidth + 8) begin
                tick();
                waited++;
            end
            if (fallCount == fallBefore) stopRun({tag, " HOLD never fell"});
            checkValue({tag, " HOLD width"}, fallCycle - riseCycle, expWidth);
            repeat (row.delay + 4) tick(); // Room for a late second HOLD
        end else begin
            repeat (row.delay + expWidth + 4) tick(); // Room for a stray HOLD
        end
        checkValue({tag, " HOLD rises"}, riseCount - riseBefore, row.expHold);
        if (row.expHold) refHolds++;
        checkValue({tag, " eventCount"}, eventCount, refHolds);
        checkValue({tag, " hold"}, hold, 0);
    endtask

    initial begin
        void'($urandom(61));
        arstN    = 1'b0;
        cmdValid = 1'b0;
        cmdWord  = '0;
        trigPins = '1;
        // prog  extra     mode  delay  time  hEn  tEn  pins  trig  hold  retrig
        rows[0]  = '{no,  16'h0000, coincAny,      8'd4,  12'd16, no,  no,  p0, yes, no,  no};
        rows[1]  = '{yes, 16'h0000, coincAny,      8'd0,  12'd1,  yes, yes, p0, yes, yes, no};
        rows[2]  = '{yes, 16'h0000, coincAny,      8'd2,  12'd3,  yes, yes, p1 | p2, yes, yes, no};
        rows[3]  = '{yes, 16'h0000, coincAny,      8'd5,  12'd0,  yes, yes, p0 | p1 | p2, yes, yes, no};
        rows[4]  = '{yes, 16'h0000, coincAny,      8'd1,  12'd2,  yes, yes, pX, no,  no,  no};
        rows[5]  = '{yes, 16'h0000, coincAll,      8'd3,  12'd4,  yes, yes, p1, no,  no,  no};
        rows[6]  = '{yes, 16'h0000, coincAll,      8'd3,  12'd4,  yes, yes, p0 | p2, no,  no,  no};
        rows[7]  = '{yes, 16'h0000, coincAll,      8'd9,  12'd7,  yes, yes, p0 | p1 | p2, yes, yes, no};
        rows[8]  = '{yes, 16'h0000, coincAll,      8'd3,  12'd4,  yes, yes, pX, no,  no,  no};
        rows[9]  = '{yes, 16'h0000, coincMajority, 8'd1,  12'd1,  yes, yes, p2, no,  no,  no};
        rows[10] = '{yes, 16'h0000, coincMajority, 8'd1,  12'd1,  yes, yes, p1 | p2, yes, yes, no};
        rows[11] = '{yes, 16'h0000, coincMajority, 8'd6,  12'd12, yes, yes, p0 | p1 | p2, yes, yes, no};
        rows[12] = '{yes, 16'h0000, coincMajority, 8'd2,  12'd2,  yes, yes, pX, no,  no,  no};
        rows[13] = '{yes, 16'h0000, coincExternal, 8'd2,  12'd2,  yes, yes, p0, no,  no,  no};
        rows[14] = '{yes, 16'h0000, coincExternal, 8'd2,  12'd2,  yes, yes, p0 | p1, no,  no,  no};
        rows[15] = '{yes, 16'h0000, coincExternal, 8'd2,  12'd2,  yes, yes, p0 | p1 | p2, no, no, no};
        rows[16] = '{yes, 16'h0000, coincExternal, 8'd3,  12'd5,  yes, yes, pX, yes, yes, no};
        rows[17] = '{yes, 16'h0000, coincAny,      8'd3,  12'd5,  no,  yes, p0, yes, no,  no};
        rows[18] = '{yes, 16'h0000, coincAny,      8'd3,  12'd5,  yes, no,  p0, yes, no,  no};
        rows[19] = '{yes, 16'h0000, coincAny,      8'd12, 12'd4,  yes, yes, p0, yes, yes, yes};
        rows[20] = '{yes, 16'h0000, coincAny,      8'd1,  12'd20, yes, yes, p0, yes, yes, yes};
        rows[21] = '{no,  16'h3005, coincAny,      8'd1,  12'd20, yes, yes, p0, yes, yes, no};
        rows[22] = '{no,  16'hD300, coincAny,      8'd1,  12'd20, yes, yes, p0, yes, yes, no};
        rows[23] = '{no,  16'hDF00, coincAny,      8'd1,  12'd20, yes, yes, p0, yes, yes, no};
        cycleLimit = ResetCycles + NumRows * (20 + worstSpan() + 8) + 200;
        repeat (ResetCycles) @(posedge Clk);
        #1;
        arstN = 1'b1;
        tick();
        checkValue("hold after reset", hold, 0);
        checkValue("trigOut after reset", trigOut, 0);
        checkValue("eventCount after reset", eventCount, 0);
        for (int i = 0; i < NumRows; i++) begin
            runRow(rows[i], i);
            repeat ($urandom_range(7)) tick(); // Idle gap
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- trigCoincid.sv
`timescale 1ns/1ps

module trigCoincid #(
    parameter int SyncStages = 2 // Synchronizer depth
) (
    input  logic                   Clk,
    input  logic                   arstN,
    input  microrocPkg::trigPins_t  trigPins,  // Asynchronous, active low
    input  microrocPkg::coincMode_t coincMode,
    output logic                   trigPulse  // One cycle per combined edge
);
    import microrocPkg::*;

    trigPins_t  syncReg [SyncStages]; // Pin synchronizer chain
    logic [2:0] asicTrig;             // Active high after sync
    logic       extTrig;
    logic       trigComb;
    logic       trigReg;

    ////////////////////////////////////////////////////////////
    // Pin synchronizer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < SyncStages; i++) begin
                syncReg[i] <= '1; // Pins idle high
            end
        end else begin
            syncReg[0] <= trigPins;
            for (int i = 1; i < SyncStages; i++) begin
                syncReg[i] <= syncReg[i-1];
            end
        end
    end

    // Back to active high
    assign asicTrig = ~{syncReg[SyncStages-1].trig2B,
                        syncReg[SyncStages-1].trig1B,
                        syncReg[SyncStages-1].trig0B};
    assign extTrig  = ~syncReg[SyncStages-1].extTrigB;

    ////////////////////////////////////////////////////////////
    // Coincidence and edge detect
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (coincMode)
            coincAny:      trigComb = |asicTrig;
            coincAll:      trigComb = &asicTrig;
            coincMajority: trigComb = (asicTrig[0] & asicTrig[1]) |
                                      (asicTrig[0] & asicTrig[2]) |
                                      (asicTrig[1] & asicTrig[2]);
            default:       trigComb = extTrig; // coincExternal
        endcase
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            trigReg   <= 1'b0;
            trigPulse <= 1'b0;
        end else begin
            trigReg   <= trigComb;
            trigPulse <= trigComb & ~trigReg; // Rising edge only
        end
    end

    // A held trigger must never retrigger
    assert property (@(posedge Clk) disable iff (!arstN)
        trigPulse |=> !trigPulse)
        else $error("trigPulse high two cycles in a row");

endmodule

//--- usbCommandDecoder.sv
`timescale 1ns/1ps

module usbCommandDecoder (
    input  logic                   Clk,
    input  logic                   arstN,
    input  logic                   cmdValid, // One-cycle strobe per word
    input  microrocPkg::cmdWord_u  cmdWord,
    output microrocPkg::daqParams_t params
);
    import microrocPkg::*;

    daqParams_t paramsNext;

    ////////////////////////////////////////////////////////////
    // Word decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        paramsNext = params; // Hold everything by default
        if (cmdValid) begin
            case (cmdWord.valueCmd.opcode) // Opcode sits on top in both views
                opCoincMode: begin
                    paramsNext.coincMode = coincMode_t'(cmdWord.valueCmd.value[1:0]);
                end
                opHoldDelay: begin
                    paramsNext.holdDelay = cmdWord.valueCmd.value[7:0];
                end
                opHoldTime: begin
                    paramsNext.holdTime = cmdWord.valueCmd.value;
                end
                opFlag: begin
                    // Flag view picks the switch by index
                    case (cmdWord.flagCmd.flagIdx)
                        flagHoldEn: paramsNext.holdEn = cmdWord.flagCmd.flagVal;
                        flagTrigEn: paramsNext.trigEn = cmdWord.flagCmd.flagVal;
                        default: begin
                            // Unknown index leaves params alone
                        end
                    endcase
                end
                default: begin
                    // Unknown opcode dropped
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Parameter register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            params <= resetParams; // Power-up parameter set
        end else begin
            params <= paramsNext;  // Visible one cycle after strobe
        end
    end

    // Mode word must fit the 2-bit mode field
    assert property (@(posedge Clk) disable iff (!arstN)
        cmdValid && (cmdWord.valueCmd.opcode == opCoincMode)
        |-> (cmdWord.valueCmd.value <= 12'd3))
        else $error("Coincidence mode word out of range");

endmodule
